//--- source/dpc_config.svh
`ifndef DPC_CONFIG_SVH
`define DPC_CONFIG_SVH

// entries in the dependency tracking table
`define DPC_TRACE_N 4

// id width, must cover more ids than instructions in flight
`define DPC_ID_WIDTH 4

`define DPC_IFQ_DEPTH 4 // instruction queue slots

// 1: short producers are bypassed instead of stalling decode
`define DPC_BYPASS_EN 1

`endif

//--- source/rv_inst_pkg.sv
package rv_inst_pkg;

	typedef logic [31:0] inst_word_t;
	typedef logic [4:0] reg_idx_t;

	// coarse opcode classes, load and muldiv are the long ones
	typedef enum logic [2:0] {
		op_alu,
		op_load,
		op_store,
		op_branch,
		op_muldiv,
		op_system
	} op_class_t;

	// major opcodes of rv32im
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_misc_mem = 7'b0001111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_system = 7'b1110011;

endpackage

//--- source/dpc_trace_pkg.sv
`include "dpc_config.svh"

package dpc_trace_pkg;

	typedef logic [`DPC_ID_WIDTH-1:0] inst_id_t;

	// one-hot life cycle of a tracked instruction
	typedef enum logic [3:0] {
		stage_free = 4'b0001,
		stage_in_queue = 4'b0010,
		stage_in_dispatch = 4'b0100,
		stage_executing = 4'b1000
	} life_stage_t;

	// what the instruction queue holds per slot
	typedef struct packed {
		rv_inst_pkg::inst_word_t inst;
		inst_id_t id;
	} ifq_entry_t;

endpackage

//--- source/inst_predecoder.sv
`timescale 1ns/10ps

module inst_predecoder (
	input rv_inst_pkg::inst_word_t inst_i,
	output rv_inst_pkg::reg_idx_t rd_o,
	output rv_inst_pkg::reg_idx_t rs1_o,
	output rv_inst_pkg::reg_idx_t rs2_o,
	output logic rd_vld_o,
	output logic is_long_o
);

	logic [6:0] opc;
	rv_inst_pkg::op_class_t cls;
	logic use_rs1;
	logic use_rs2;

	assign opc = inst_i[6:0];

	always_comb
	begin
		cls = rv_inst_pkg::op_system; // fence, ecall and unknown words
		rd_vld_o = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opc)
			rv_inst_pkg::opc_op:
			begin
				cls = (inst_i[31:25] == 7'b0000001) ? rv_inst_pkg::op_muldiv : rv_inst_pkg::op_alu;
				rd_vld_o = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_inst_pkg::opc_op_imm:
			begin
				cls = rv_inst_pkg::op_alu;
				rd_vld_o = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_inst_pkg::opc_lui, rv_inst_pkg::opc_auipc:
			begin
				cls = rv_inst_pkg::op_alu;
				rd_vld_o = 1'b1; // no source register in u-type
			end
			rv_inst_pkg::opc_load:
			begin
				cls = rv_inst_pkg::op_load;
				rd_vld_o = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_inst_pkg::opc_store:
			begin
				cls = rv_inst_pkg::op_store;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_inst_pkg::opc_branch:
			begin
				cls = rv_inst_pkg::op_branch;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_inst_pkg::opc_jal:
			begin
				cls = rv_inst_pkg::op_branch;
				rd_vld_o = 1'b1; // link register
			end
			rv_inst_pkg::opc_jalr:
			begin
				cls = rv_inst_pkg::op_branch;
				rd_vld_o = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_inst_pkg::opc_system:
			begin
				// csr access writes rd, register forms also read rs1
				rd_vld_o = (inst_i[14:12] != 3'b000);
				use_rs1 = (inst_i[14:12] != 3'b000) && !inst_i[14];
			end
			default:
			begin
				cls = rv_inst_pkg::op_system;
			end
		endcase
	end

	assign rd_o = inst_i[11:7];
	assign rs1_o = use_rs1 ? inst_i[19:15] : '0; // x0 never causes a hazard
	assign rs2_o = use_rs2 ? inst_i[24:20] : '0;
	assign is_long_o = (cls == rv_inst_pkg::op_load) || (cls == rv_inst_pkg::op_muldiv);

endmodule

//--- source/inst_queue.sv
`timescale 1ns/10ps

module inst_queue #(
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic resetn,
	input logic flush_i,
	input logic push_i,
	input dpc_trace_pkg::ifq_entry_t push_data_i,
	input logic pop_i,
	output dpc_trace_pkg::ifq_entry_t head_o,
	output logic empty_o,
	output logic full_o
);

	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cnt_w = $clog2(DEPTH + 1);

	dpc_trace_pkg::ifq_entry_t mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty_o = (count == '0);
	assign full_o = (count == cnt_w'(DEPTH));
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			wr_ptr <= '0; // drops pending push and pop too
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push && !flush_i)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

//--- source/dpc_monitor.sv
`timescale 1ns/10ps

`include "dpc_config.svh"

module dpc_monitor #(
	parameter int TRACE_N = 4,
	parameter int ID_WIDTH = 4
) (
	input logic clk,
	input logic resetn,
	input logic flush_i,
	output logic table_full_o,

	// instruction enters the queue
	input rv_inst_pkg::inst_word_t enter_inst_i,
	input rv_inst_pkg::reg_idx_t enter_rd_i,
	input logic enter_rd_vld_i,
	input logic enter_is_long_i,
	input logic [ID_WIDTH-1:0] enter_id_i,
	input logic enter_valid_i,

	// life cycle events
	input logic [ID_WIDTH-1:0] dcd_id_i,
	input logic dcd_valid_i,
	input logic [ID_WIDTH-1:0] dsptc_id_i,
	input logic dsptc_valid_i,
	input logic [ID_WIDTH-1:0] retire_id_i,
	input logic retire_valid_i,

	// hazard checks
	input rv_inst_pkg::reg_idx_t dcd_rs1_i,
	input rv_inst_pkg::reg_idx_t dcd_rs2_i,
	output logic dcd_rs1_raw_o,
	output logic dcd_rs2_raw_o,
	input rv_inst_pkg::reg_idx_t dsptc_rd_i,
	output logic dsptc_rd_waw_o,
	output logic bypass_rs1_o,
	output logic bypass_rs2_o
);

	localparam bit bypass_en = (`DPC_BYPASS_EN != 0);

	// per entry record
	typedef struct packed {
		rv_inst_pkg::reg_idx_t rd;
		logic is_long;
		logic [ID_WIDTH-1:0] id;
	} trace_rec_t;

	dpc_trace_pkg::life_stage_t stage [TRACE_N];
	trace_rec_t rec [TRACE_N];

	logic [TRACE_N-1:0] free_vec;
	logic [TRACE_N-1:0] grant_vec;
	logic [TRACE_N-1:0] dcd_hit;
	logic [TRACE_N-1:0] dsp_hit;
	logic [TRACE_N-1:0] ret_hit;
	logic [TRACE_N-1:0] live_vec;
	logic [TRACE_N-1:0] rs1_raw_vec;
	logic [TRACE_N-1:0] rs2_raw_vec;
	logic [TRACE_N-1:0] rs1_bp_vec;
	logic [TRACE_N-1:0] rs2_bp_vec;
	logic [TRACE_N-1:0] waw_vec;
	logic free_seen;

	always_comb
	begin
		free_seen = 1'b0;
		for (int i = 0; i < TRACE_N; i++)
		begin
			free_vec[i] = (stage[i] == dpc_trace_pkg::stage_free);
			grant_vec[i] = free_vec[i] && !free_seen; // lowest free entry wins
			free_seen = free_seen || free_vec[i];

			dcd_hit[i] = dcd_valid_i && (rec[i].id == dcd_id_i);
			dsp_hit[i] = dsptc_valid_i && (rec[i].id == dsptc_id_i);
			ret_hit[i] = retire_valid_i && (rec[i].id == retire_id_i);

			// producer already past decode with a real destination
			live_vec[i] = ((stage[i] == dpc_trace_pkg::stage_in_dispatch) ||
				(stage[i] == dpc_trace_pkg::stage_executing)) && (rec[i].rd != '0);

			rs1_raw_vec[i] = live_vec[i] && (rec[i].rd == dcd_rs1_i) &&
				(rec[i].is_long || !bypass_en);
			rs2_raw_vec[i] = live_vec[i] && (rec[i].rd == dcd_rs2_i) &&
				(rec[i].is_long || !bypass_en);
			rs1_bp_vec[i] = live_vec[i] && (rec[i].rd == dcd_rs1_i) &&
				!rec[i].is_long && bypass_en;
			rs2_bp_vec[i] = live_vec[i] && (rec[i].rd == dcd_rs2_i) &&
				!rec[i].is_long && bypass_en;

			// only long instructions in execution can still write late
			waw_vec[i] = (stage[i] == dpc_trace_pkg::stage_executing) && rec[i].is_long &&
				(rec[i].rd != '0) && (rec[i].rd == dsptc_rd_i);
		end
	end

	assign table_full_o = ~|free_vec;
	assign dcd_rs1_raw_o = |rs1_raw_vec;
	assign dcd_rs2_raw_o = |rs2_raw_vec;
	assign bypass_rs1_o = |rs1_bp_vec;
	assign bypass_rs2_o = |rs2_bp_vec;
	assign dsptc_rd_waw_o = |waw_vec;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < TRACE_N; i++)
				stage[i] <= dpc_trace_pkg::stage_free;
		end
		else
		begin
			for (int i = 0; i < TRACE_N; i++)
			begin
				// flush spares executing entries and one dispatching right now
				if (flush_i && (stage[i] != dpc_trace_pkg::stage_executing) &&
					!((stage[i] == dpc_trace_pkg::stage_in_dispatch) && dsp_hit[i]))
					stage[i] <= dpc_trace_pkg::stage_free;
				else
				begin
					case (stage[i])
						dpc_trace_pkg::stage_free:
							if (enter_valid_i && grant_vec[i])
								stage[i] <= dpc_trace_pkg::stage_in_queue;
						dpc_trace_pkg::stage_in_queue:
							if (dcd_hit[i])
								stage[i] <= dpc_trace_pkg::stage_in_dispatch;
						dpc_trace_pkg::stage_in_dispatch:
							if (dsp_hit[i])
								stage[i] <= ret_hit[i] ? dpc_trace_pkg::stage_free :
									dpc_trace_pkg::stage_executing;
						dpc_trace_pkg::stage_executing:
							if (ret_hit[i])
								stage[i] <= dpc_trace_pkg::stage_free;
						default:
							stage[i] <= dpc_trace_pkg::stage_free;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < TRACE_N; i++)
		begin
			if (free_vec[i] && grant_vec[i] && enter_valid_i)
			begin
				rec[i].rd <= enter_rd_vld_i ? enter_rd_i : '0; // no write means x0
				rec[i].is_long <= enter_is_long_i;
				rec[i].id <= enter_id_i;
			end
		end
	end

endmodule

//--- source/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
	input logic clk,
	input logic resetn,
	input logic flush_i,

	input logic fetch_valid_i,
	input rv_inst_pkg::inst_word_t fetch_inst_i,
	output logic fetch_ready_o,

	// instruction queue
	output logic queue_push_o,
	output dpc_trace_pkg::ifq_entry_t queue_push_data_o,
	output logic queue_pop_o,
	input dpc_trace_pkg::ifq_entry_t queue_head_i,
	input logic queue_empty_i,
	input logic queue_full_i,

	// dependency tracker
	input logic table_full_i,
	output rv_inst_pkg::inst_word_t enter_inst_o,
	output rv_inst_pkg::reg_idx_t enter_rd_o,
	output logic enter_rd_vld_o,
	output logic enter_is_long_o,
	output dpc_trace_pkg::inst_id_t enter_id_o,
	output logic enter_valid_o,
	output dpc_trace_pkg::inst_id_t dcd_id_o,
	output logic dcd_valid_o,
	output dpc_trace_pkg::inst_id_t dsptc_id_o,
	output logic dsptc_valid_o,
	output dpc_trace_pkg::inst_id_t retire_id_o,
	output logic retire_valid_o,
	output rv_inst_pkg::reg_idx_t dcd_rs1_o,
	output rv_inst_pkg::reg_idx_t dcd_rs2_o,
	input logic dcd_rs1_raw_i,
	input logic dcd_rs2_raw_i,
	output rv_inst_pkg::reg_idx_t dsptc_rd_o,
	input logic dsptc_rd_waw_i,
	input logic bypass_rs1_i,
	input logic bypass_rs2_i,

	input logic exec_ready_i,
	input logic long_done_valid_i,
	input dpc_trace_pkg::inst_id_t long_done_id_i,

	output logic dispatch_valid_o,
	output rv_inst_pkg::inst_word_t dispatch_inst_o,
	output dpc_trace_pkg::inst_id_t dispatch_id_o,
	output logic dispatch_bypass_rs1_o,
	output logic dispatch_bypass_rs2_o
);

	dpc_trace_pkg::inst_id_t id_cnt;
	logic accept;
	logic decode;
	logic dsp_fire;

	rv_inst_pkg::reg_idx_t head_rd;
	logic head_rd_vld;
	logic head_is_long;

	// dispatch register
	logic dsp_valid;
	dpc_trace_pkg::ifq_entry_t dsp_entry;
	rv_inst_pkg::reg_idx_t dsp_rd;
	logic dsp_is_long;

	inst_predecoder u_fetch_predec (
		.inst_i(fetch_inst_i),
		.rd_o(enter_rd_o),
		.rs1_o(),
		.rs2_o(),
		.rd_vld_o(enter_rd_vld_o),
		.is_long_o(enter_is_long_o)
	);

	inst_predecoder u_head_predec (
		.inst_i(queue_head_i.inst),
		.rd_o(head_rd),
		.rs1_o(dcd_rs1_o),
		.rs2_o(dcd_rs2_o),
		.rd_vld_o(head_rd_vld),
		.is_long_o(head_is_long)
	);

	assign fetch_ready_o = !queue_full_i && !table_full_i && !flush_i;
	assign accept = fetch_valid_i && fetch_ready_o;

	assign queue_push_o = accept;
	assign queue_push_data_o = '{inst: fetch_inst_i, id: id_cnt};
	assign enter_valid_o = accept;
	assign enter_inst_o = fetch_inst_i;
	assign enter_id_o = id_cnt;

	// short ones need the retire port in the same cycle
	assign dsp_fire = dsp_valid && exec_ready_i && !dsptc_rd_waw_i &&
		(dsp_is_long || !long_done_valid_i);
	assign decode = !queue_empty_i && (!dsp_valid || dsp_fire) &&
		!dcd_rs1_raw_i && !dcd_rs2_raw_i && !flush_i;

	assign queue_pop_o = decode;
	assign dcd_valid_o = decode;
	assign dcd_id_o = queue_head_i.id;

	assign dsptc_valid_o = dsp_fire;
	assign dsptc_id_o = dsp_entry.id;
	assign dsptc_rd_o = dsp_rd;

	// long completion first
	assign retire_valid_o = long_done_valid_i || (dsp_fire && !dsp_is_long);
	assign retire_id_o = long_done_valid_i ? long_done_id_i : dsp_entry.id;

	assign dispatch_valid_o = dsp_fire;
	assign dispatch_inst_o = dsp_entry.inst;
	assign dispatch_id_o = dsp_entry.id;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			id_cnt <= '0;
		else if (accept)
			id_cnt <= id_cnt + 1'b1; // wraps, ids in flight stay unique
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			dsp_valid <= 1'b0;
			dispatch_bypass_rs1_o <= 1'b0;
			dispatch_bypass_rs2_o <= 1'b0;
		end
		else if (flush_i)
		begin
			dsp_valid <= 1'b0;
			dispatch_bypass_rs1_o <= 1'b0;
			dispatch_bypass_rs2_o <= 1'b0;
		end
		else if (decode)
		begin
			dsp_valid <= 1'b1;
			dispatch_bypass_rs1_o <= bypass_rs1_i;
			dispatch_bypass_rs2_o <= bypass_rs2_i;
		end
		else if (dsp_fire)
			dsp_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (decode)
		begin
			dsp_entry <= queue_head_i;
			dsp_rd <= head_rd_vld ? head_rd : '0;
			dsp_is_long <= head_is_long;
		end
	end

endmodule

//--- source/dpc_frontend_top.sv
`timescale 1ns/10ps

`include "dpc_config.svh"

module dpc_frontend_top (
	input logic clk,
	input logic resetn,
	input logic flush_i,
	input logic fetch_valid_i,
	input rv_inst_pkg::inst_word_t fetch_inst_i,
	output logic fetch_ready_o,
	input logic exec_ready_i,
	input logic long_done_valid_i,
	input dpc_trace_pkg::inst_id_t long_done_id_i,
	output logic dispatch_valid_o,
	output rv_inst_pkg::inst_word_t dispatch_inst_o,
	output dpc_trace_pkg::inst_id_t dispatch_id_o,
	output logic dispatch_bypass_rs1_o,
	output logic dispatch_bypass_rs2_o
);

	// queue side
	logic queue_push;
	dpc_trace_pkg::ifq_entry_t queue_push_data;
	logic queue_pop;
	dpc_trace_pkg::ifq_entry_t queue_head;
	logic queue_empty;
	logic queue_full;

	// tracker side
	logic table_full;
	rv_inst_pkg::inst_word_t enter_inst;
	rv_inst_pkg::reg_idx_t enter_rd;
	logic enter_rd_vld;
	logic enter_is_long;
	dpc_trace_pkg::inst_id_t enter_id;
	logic enter_valid;
	dpc_trace_pkg::inst_id_t dcd_id;
	logic dcd_valid;
	dpc_trace_pkg::inst_id_t dsptc_id;
	logic dsptc_valid;
	dpc_trace_pkg::inst_id_t retire_id;
	logic retire_valid;
	rv_inst_pkg::reg_idx_t dcd_rs1;
	rv_inst_pkg::reg_idx_t dcd_rs2;
	logic dcd_rs1_raw;
	logic dcd_rs2_raw;
	rv_inst_pkg::reg_idx_t dsptc_rd;
	logic dsptc_rd_waw;
	logic bypass_rs1;
	logic bypass_rs2;

	inst_queue #(
		.DEPTH(`DPC_IFQ_DEPTH)
	) u_queue (
		.clk(clk),
		.resetn(resetn),
		.flush_i(flush_i),
		.push_i(queue_push),
		.push_data_i(queue_push_data),
		.pop_i(queue_pop),
		.head_o(queue_head),
		.empty_o(queue_empty),
		.full_o(queue_full)
	);

	dpc_monitor #(
		.TRACE_N(`DPC_TRACE_N),
		.ID_WIDTH(`DPC_ID_WIDTH)
	) u_monitor (
		.clk(clk),
		.resetn(resetn),
		.flush_i(flush_i),
		.table_full_o(table_full),
		.enter_inst_i(enter_inst),
		.enter_rd_i(enter_rd),
		.enter_rd_vld_i(enter_rd_vld),
		.enter_is_long_i(enter_is_long),
		.enter_id_i(enter_id),
		.enter_valid_i(enter_valid),
		.dcd_id_i(dcd_id),
		.dcd_valid_i(dcd_valid),
		.dsptc_id_i(dsptc_id),
		.dsptc_valid_i(dsptc_valid),
		.retire_id_i(retire_id),
		.retire_valid_i(retire_valid),
		.dcd_rs1_i(dcd_rs1),
		.dcd_rs2_i(dcd_rs2),
		.dcd_rs1_raw_o(dcd_rs1_raw),
		.dcd_rs2_raw_o(dcd_rs2_raw),
		.dsptc_rd_i(dsptc_rd),
		.dsptc_rd_waw_o(dsptc_rd_waw),
		.bypass_rs1_o(bypass_rs1),
		.bypass_rs2_o(bypass_rs2)
	);

	issue_stage u_issue (
		.clk(clk),
		.resetn(resetn),
		.flush_i(flush_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_inst_i(fetch_inst_i),
		.fetch_ready_o(fetch_ready_o),
		.queue_push_o(queue_push),
		.queue_push_data_o(queue_push_data),
		.queue_pop_o(queue_pop),
		.queue_head_i(queue_head),
		.queue_empty_i(queue_empty),
		.queue_full_i(queue_full),
		.table_full_i(table_full),
		.enter_inst_o(enter_inst),
		.enter_rd_o(enter_rd),
		.enter_rd_vld_o(enter_rd_vld),
		.enter_is_long_o(enter_is_long),
		.enter_id_o(enter_id),
		.enter_valid_o(enter_valid),
		.dcd_id_o(dcd_id),
		.dcd_valid_o(dcd_valid),
		.dsptc_id_o(dsptc_id),
		.dsptc_valid_o(dsptc_valid),
		.retire_id_o(retire_id),
		.retire_valid_o(retire_valid),
		.dcd_rs1_o(dcd_rs1),
		.dcd_rs2_o(dcd_rs2),
		.dcd_rs1_raw_i(dcd_rs1_raw),
		.dcd_rs2_raw_i(dcd_rs2_raw),
		.dsptc_rd_o(dsptc_rd),
		.dsptc_rd_waw_i(dsptc_rd_waw),
		.bypass_rs1_i(bypass_rs1),
		.bypass_rs2_i(bypass_rs2),
		.exec_ready_i(exec_ready_i),
		.long_done_valid_i(long_done_valid_i),
		.long_done_id_i(long_done_id_i),
		.dispatch_valid_o(dispatch_valid_o),
		.dispatch_inst_o(dispatch_inst_o),
		.dispatch_id_o(dispatch_id_o),
		.dispatch_bypass_rs1_o(dispatch_bypass_rs1_o),
		.dispatch_bypass_rs2_o(dispatch_bypass_rs2_o)
	);

endmodule

//--- test/dpc_checker.sv
`timescale 1ns/10ps

`include "dpc_config.svh"

module dpc_checker (
	input logic clk,
	input logic resetn,
	input logic flush_i,
	input logic fetch_valid_i,
	input rv_inst_pkg::inst_word_t fetch_inst_i,
	input logic fetch_ready_i,
	input logic long_done_valid_i,
	input dpc_trace_pkg::inst_id_t long_done_id_i,
	input logic dispatch_valid_i,
	input rv_inst_pkg::inst_word_t dispatch_inst_i,
	input dpc_trace_pkg::inst_id_t dispatch_id_i,
	input logic dispatch_bypass_rs1_i,
	input logic dispatch_bypass_rs2_i,
	output int err_count_o,
	output int pending_o,
	output int dispatch_count_o
);

	rv_inst_pkg::inst_word_t exp_word_q[$]; // accepted, not yet dispatched
	dpc_trace_pkg::inst_id_t exp_id_q[$];
	logic [4:0] busy_rd_q[$]; // dispatched long ones without completion
	dpc_trace_pkg::inst_id_t busy_id_q[$];
	dpc_trace_pkg::inst_id_t next_id;
	int cycle_no;
	int prev_cycle;
	logic prev_vld;
	logic prev_short;
	logic [4:0] prev_rd;

	// {long, rd, rs1, rs2} for the formats that are driven, unused fields read as x0
	function automatic logic [15:0] decode_fields(input logic [31:0] w);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic lng;
		begin
			rd = 5'd0;
			rs1 = 5'd0;
			rs2 = 5'd0;
			lng = 1'b0;
			case (w[6:0])
				7'b0110011:
				begin
					rd = w[11:7];
					rs1 = w[19:15];
					rs2 = w[24:20];
					lng = (w[31:25] == 7'b0000001); // mul and div
				end
				7'b0010011:
				begin
					rd = w[11:7];
					rs1 = w[19:15];
				end
				7'b0000011:
				begin
					rd = w[11:7];
					rs1 = w[19:15];
					lng = 1'b1;
				end
				7'b0100011, 7'b1100011:
				begin
					rs1 = w[19:15];
					rs2 = w[24:20];
				end
				default:
					lng = 1'b0;
			endcase
			return {lng, rd, rs1, rs2};
		end
	endfunction

	// bypass rule for one source, returns 1 on a violation
	function automatic logic bypass_wrong(input logic flag, input logic [4:0] src, input int now);
		logic may;
		begin
			may = prev_vld && prev_short && (prev_rd != 5'd0) && (prev_rd == src);
			if (flag && !may)
				return 1'b1;
			if ((`DPC_BYPASS_EN != 0) && may && (prev_cycle == now - 1) && !flag)
				return 1'b1;
			return 1'b0;
		end
	endfunction

	always @(posedge clk or negedge resetn)
	begin : compare
		logic [15:0] f;
		int k;
		if (!resetn)
		begin
			exp_word_q.delete();
			exp_id_q.delete();
			busy_rd_q.delete();
			busy_id_q.delete();
			next_id = '0;
			cycle_no = 0;
			prev_vld = 1'b0;
			err_count_o = 0;
			dispatch_count_o = 0;
		end
		else
		begin
			cycle_no++;
			if (dispatch_valid_i)
			begin
				dispatch_count_o++;
				f = decode_fields(dispatch_inst_i);
				if (exp_word_q.size() == 0)
				begin
					$display("error at %0t: unexpected dispatch of id %0d", $time, dispatch_id_i);
					err_count_o++;
				end
				else
				begin
					if (dispatch_inst_i !== exp_word_q[0] || dispatch_id_i !== exp_id_q[0])
					begin
						$display("error at %0t: dispatched %h id %0d, expected %h id %0d", $time,
							dispatch_inst_i, dispatch_id_i, exp_word_q[0], exp_id_q[0]);
						err_count_o++;
					end
					void'(exp_word_q.pop_front());
					void'(exp_id_q.pop_front());
				end
				for (k = 0; k < busy_rd_q.size(); k++)
				begin
					if (busy_rd_q[k] != 5'd0 && (busy_rd_q[k] == f[9:5] || busy_rd_q[k] == f[4:0]))
					begin
						$display("error at %0t: raw on x%0d against id %0d", $time,
							busy_rd_q[k], busy_id_q[k]);
						err_count_o++;
					end
					if (busy_rd_q[k] != 5'd0 && busy_rd_q[k] == f[14:10])
					begin
						$display("error at %0t: waw on x%0d against id %0d", $time,
							busy_rd_q[k], busy_id_q[k]);
						err_count_o++;
					end
				end
				if (bypass_wrong(dispatch_bypass_rs1_i, f[9:5], cycle_no) ||
					bypass_wrong(dispatch_bypass_rs2_i, f[4:0], cycle_no))
				begin
					$display("error at %0t: wrong bypass flags %b%b on id %0d", $time,
						dispatch_bypass_rs1_i, dispatch_bypass_rs2_i, dispatch_id_i);
					err_count_o++;
				end
				if (f[15])
				begin
					busy_rd_q.push_back(f[14:10]);
					busy_id_q.push_back(dispatch_id_i);
				end
				prev_vld = 1'b1;
				prev_short = !f[15];
				prev_rd = f[14:10];
				prev_cycle = cycle_no;
			end
			if (long_done_valid_i)
			begin
				for (k = busy_id_q.size() - 1; k >= 0; k--)
				begin
					if (busy_id_q[k] == long_done_id_i)
					begin
						busy_id_q.delete(k);
						busy_rd_q.delete(k);
					end
				end
			end
			if (flush_i)
			begin
				exp_word_q.delete(); // dropped before dispatch
				exp_id_q.delete();
			end
			if (fetch_valid_i && fetch_ready_i)
			begin
				exp_word_q.push_back(fetch_inst_i);
				exp_id_q.push_back(next_id);
				next_id = next_id + 1'b1;
			end
		end
		pending_o = exp_word_q.size();
	end

endmodule

//--- test/tb_dpc_frontend.sv
`timescale 1ns/10ps

module tb_dpc_frontend;

	localparam int wait_limit = 300;

	logic clk;
	logic resetn;
	logic flush_i;
	logic fetch_valid_i;
	rv_inst_pkg::inst_word_t fetch_inst_i;
	logic fetch_ready_o;
	logic exec_ready_i;
	logic long_done_valid_i;
	dpc_trace_pkg::inst_id_t long_done_id_i;
	logic dispatch_valid_o;
	rv_inst_pkg::inst_word_t dispatch_inst_o;
	dpc_trace_pkg::inst_id_t dispatch_id_o;
	logic dispatch_bypass_rs1_o;
	logic dispatch_bypass_rs2_o;

	int err_count;
	int pending;
	int dispatched;
	int tb_errors;
	int timeouts;
	bit hold_done; // withholds long completions
	bit exec_stall; // keeps exec_ready low
	dpc_trace_pkg::inst_id_t done_id_q[$];
	int done_dly_q[$];

	dpc_frontend_top UUT (
		.clk(clk),
		.resetn(resetn),
		.flush_i(flush_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_inst_i(fetch_inst_i),
		.fetch_ready_o(fetch_ready_o),
		.exec_ready_i(exec_ready_i),
		.long_done_valid_i(long_done_valid_i),
		.long_done_id_i(long_done_id_i),
		.dispatch_valid_o(dispatch_valid_o),
		.dispatch_inst_o(dispatch_inst_o),
		.dispatch_id_o(dispatch_id_o),
		.dispatch_bypass_rs1_o(dispatch_bypass_rs1_o),
		.dispatch_bypass_rs2_o(dispatch_bypass_rs2_o)
	);

	dpc_checker u_checker (
		.clk(clk),
		.resetn(resetn),
		.flush_i(flush_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_inst_i(fetch_inst_i),
		.fetch_ready_i(fetch_ready_o),
		.long_done_valid_i(long_done_valid_i),
		.long_done_id_i(long_done_id_i),
		.dispatch_valid_i(dispatch_valid_o),
		.dispatch_inst_i(dispatch_inst_o),
		.dispatch_id_i(dispatch_id_o),
		.dispatch_bypass_rs1_i(dispatch_bypass_rs1_o),
		.dispatch_bypass_rs2_i(dispatch_bypass_rs2_o),
		.err_count_o(err_count),
		.pending_o(pending),
		.dispatch_count_o(dispatched)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic logic is_long_word(input logic [31:0] w);
		return (w[6:0] == 7'b0000011) || (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000001);
	endfunction

	// mostly x1..x3 so hazards show up
	function automatic logic [4:0] rand_reg();
		if ($urandom % 8 < 6)
			return 5'(1 + $urandom % 3);
		return 5'($urandom % 32);
	endfunction

	function automatic logic [31:0] rand_inst();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		begin
			rd = rand_reg();
			rs1 = rand_reg();
			rs2 = rand_reg();
			case ($urandom % 6)
				0: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
				1: return {12'($urandom), rs1, 3'b000, rd, 7'b0010011};
				2: return {12'($urandom), rs1, 3'b010, rd, 7'b0000011};
				3: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
				4: return {7'b0000000, rs2, rs1, 3'b010, 5'd4, 7'b0100011};
				default: return {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b1100011};
			endcase
		end
	endfunction

	// long completion model that also drives exec_ready
	always @(posedge clk)
	begin : done_model
		int k;
		if (resetn && dispatch_valid_o && is_long_word(dispatch_inst_o))
		begin
			done_id_q.push_back(dispatch_id_o);
			done_dly_q.push_back($urandom % 7);
		end
		#2;
		long_done_valid_i = 1'b0;
		for (k = 0; k < done_dly_q.size(); k++)
			if (done_dly_q[k] > 0)
				done_dly_q[k]--;
		for (k = 0; k < done_dly_q.size(); k++)
		begin
			if (!hold_done && !long_done_valid_i && done_dly_q[k] == 0)
			begin
				long_done_valid_i = 1'b1;
				long_done_id_i = done_id_q[k];
				done_id_q.delete(k);
				done_dly_q.delete(k);
			end
		end
		exec_ready_i = exec_stall ? 1'b0 : ($urandom % 4 != 0);
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send_inst(input logic [31:0] w);
		int n;
		begin
			n = 0;
			fetch_valid_i = 1'b1;
			fetch_inst_i = w;
			@(posedge clk);
			while (!fetch_ready_o && n < wait_limit)
			begin
				n++;
				@(posedge clk);
			end
			if (n >= wait_limit)
			begin
				$display("timeout: fetch_ready stayed low while sending an instruction");
				timeouts++;
			end
			#2 fetch_valid_i = 1'b0;
			if ($urandom % 4 == 0)
				next_cycle();
		end
	endtask

	task automatic pulse_flush();
		flush_i = 1'b1;
		next_cycle();
		flush_i = 1'b0;
	endtask

	task automatic stall_until_full();
		int n;
		int base;
		bit full_seen;
		begin
			@(posedge clk);
			#1;
			exec_stall = 1'b1;
			hold_done = 1'b1;
			repeat (2)
				next_cycle();
			base = dispatched;
			n = 0;
			full_seen = 1'b0;
			fetch_valid_i = 1'b1;
			while (!full_seen && n < wait_limit)
			begin
				fetch_inst_i = rand_inst();
				@(posedge clk);
				if (!fetch_ready_o)
					full_seen = 1'b1;
				n++;
				#2;
			end
			fetch_valid_i = 1'b0;
			if (!full_seen)
			begin
				$display("timeout: fetch_ready never fell under back-pressure");
				timeouts++;
			end
			repeat (5)
				next_cycle();
			if (dispatched != base)
			begin
				$display("error at %0t: dispatch while exec_ready was low", $time);
				tb_errors++;
			end
			@(posedge clk);
			#1;
			exec_stall = 1'b0;
			hold_done = 1'b0;
			#1;
		end
	endtask

	task automatic drain_queue();
		int n;
		begin
			n = 0;
			while (pending != 0 && n < 20 * wait_limit)
			begin
				n++;
				next_cycle();
			end
			if (pending != 0)
			begin
				$display("timeout: %0d accepted instructions never dispatched", pending);
				timeouts++;
			end
		end
	endtask

	initial
	begin
		void'($urandom(97953));
		resetn = 1'b0;
		flush_i = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_inst_i = '0;
		exec_ready_i = 1'b0;
		long_done_valid_i = 1'b0;
		long_done_id_i = '0;
		hold_done = 1'b0;
		exec_stall = 1'b0;
		tb_errors = 0;
		timeouts = 0;
		repeat (10)
			@(posedge clk);
		#2 resetn = 1'b1;
		next_cycle();
		if (!fetch_ready_o || dispatch_valid_o || dispatch_bypass_rs1_o || dispatch_bypass_rs2_o)
		begin
			$display("error at %0t: outputs not in reset state", $time);
			tb_errors++;
		end

		repeat (150)
			send_inst(rand_inst());
		drain_queue();

		repeat (8)
		begin
			repeat (1 + $urandom % 8)
				send_inst(rand_inst());
			pulse_flush(); // random point in the pipeline
		end
		repeat (40)
			send_inst(rand_inst());
		drain_queue();

		stall_until_full();
		repeat (30)
			send_inst(rand_inst());
		drain_queue();

		repeat (5)
			next_cycle();
		$display("result: %0d check errors, %0d testbench errors, %0d timeouts, %0d dispatched",
			err_count, tb_errors, timeouts, dispatched);
		if (err_count == 0 && tb_errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
source/rv_inst_pkg.sv
source/dpc_trace_pkg.sv
source/inst_predecoder.sv
source/inst_queue.sv
source/dpc_monitor.sv
source/issue_stage.sv
source/dpc_frontend_top.sv
test/dpc_checker.sv
test/tb_dpc_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, pass is decided from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_dpc_frontend \
	-o sim_dpc > build.log 2>&1 \
	&& ./obj_dir/sim_dpc > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^Simulation passed$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
